//--- hdl/cluster_macros.svh
/*
 * Cluster-wide constants for mesh size, address map and transfer widths.
 * Include before importing the cluster or DMA packages.
 */
`default_nettype none

`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Mesh of groups
`define NUM_X 2
`define NUM_Y 2

// Transfer geometry
`define BEAT_BYTES 4
`define ADDR_W 32
`define LEN_W 12

// TCDM address map, one slice per group
`define TCDM_BASE 32'h0010_0000
`define GROUP_SPAN 32'h0001_0000

`endif

`default_nettype wire

//--- hdl/cluster_cfg_pkg.sv
/*
 * Cluster layout types: number of groups and the group index.
 */
`include "cluster_macros.svh"
`default_nettype none

package cluster_cfg_pkg;

  // Groups in the mesh
  localparam int unsigned NumGroups = `NUM_X * `NUM_Y;

  localparam int unsigned GroupIdW = $clog2(NumGroups);

  // Linear group index, x * NUM_Y + y
  typedef logic [GroupIdW-1:0] group_id_t;

endpackage : cluster_cfg_pkg

`default_nettype wire

//--- hdl/dma_pkg.sv
/*
 * DMA traffic types shared by the request path and the status path.
 */
`include "cluster_macros.svh"
`default_nettype none

package dma_pkg;

  // One transfer as issued by the host
  typedef struct packed {
    logic [`ADDR_W-1:0] src_addr;
    logic [`ADDR_W-1:0] dst_addr;
    logic [`LEN_W-1:0]  num_bytes;
  } dma_req_t;

  // Status counters wrap at 2**MetaCntW
  localparam int unsigned MetaCntW = 8;

  // Per-group status seen by the host
  typedef struct packed {
    logic                busy;
    logic [MetaCntW-1:0] num_done;
    logic [MetaCntW-1:0] num_err;
  } dma_meta_t;

endpackage : dma_pkg

`default_nettype wire

//--- hdl/spill_register.sv
/*
 * Two-entry valid/ready register for any payload type.
 * Registers data, valid and ready, so no combinational path crosses it.
 */
`timescale 1ns/10ps
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic head_full_q, head_full_d;
  logic spill_full_q, spill_full_d;
  T     head_data_q;
  T     spill_data_q;
  logic push, pop;
  logic head_load, head_from_spill, spill_load;

  // Spill slot only fills behind a full head
  assign ready_o = ~spill_full_q;
  assign valid_o = head_full_q;
  assign data_o  = head_data_q;

  assign push = valid_i & ready_o;
  assign pop  = head_full_q & ready_i;

  always_comb begin
    head_full_d     = head_full_q;
    spill_full_d    = spill_full_q;
    head_load       = 1'b0;
    head_from_spill = 1'b0;
    spill_load      = 1'b0;
    if (pop) begin
      if (spill_full_q) begin
        // Older item moves up
        head_from_spill = 1'b1;
        spill_full_d    = push;
        spill_load      = push;
      end else begin
        head_full_d = push;
        head_load   = push;
      end
    end else if (push) begin
      if (head_full_q) begin
        spill_full_d = 1'b1;
        spill_load   = 1'b1;
      end else begin
        head_full_d = 1'b1;
        head_load   = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      head_full_q  <= head_full_d;
      spill_full_q <= spill_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (head_from_spill) begin
      head_data_q <= spill_data_q;
    end else if (head_load) begin
      head_data_q <= data_i;
    end
    if (spill_load) begin
      spill_data_q <= data_i;
    end
  end

endmodule : spill_register

`default_nettype wire

//--- hdl/dma_req_frontend.sv
/*
 * Request front end: one spill register per group lane between the
 * cluster DMA ports and the group engines.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_req_frontend (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // Host side
  input  dma_pkg::dma_req_t   [cluster_cfg_pkg::NumGroups-1:0] dma_req_i,
  input  logic                [cluster_cfg_pkg::NumGroups-1:0] dma_req_valid_i,
  output logic                [cluster_cfg_pkg::NumGroups-1:0] dma_req_ready_o,
  // Group side
  output dma_pkg::dma_req_t   [cluster_cfg_pkg::NumGroups-1:0] grp_req_o,
  output logic                [cluster_cfg_pkg::NumGroups-1:0] grp_req_valid_o,
  input  logic                [cluster_cfg_pkg::NumGroups-1:0] grp_req_ready_i
);

  import dma_pkg::*;
  import cluster_cfg_pkg::*;

  // Lanes are independent, a stalled group only backs up its own port
  for (genvar g = 0; g < NumGroups; g++) begin : gen_lane
    spill_register #(
      .T (dma_req_t)
    ) i_req_spill (
      .clk_i    (clk_i             ),
      .arst_n_i (arst_n_i          ),
      .valid_i  (dma_req_valid_i[g]),
      .ready_o  (dma_req_ready_o[g]),
      .data_i   (dma_req_i[g]      ),
      .valid_o  (grp_req_valid_o[g]),
      .ready_i  (grp_req_ready_i[g]),
      .data_o   (grp_req_o[g]      )
    );
  end : gen_lane

endmodule : dma_req_frontend

`default_nettype wire

//--- hdl/group_dma_engine.sv
/*
 * DMA backend of one group. Checks the destination against the group's
 * TCDM slice, runs one cycle per beat and counts completions and errors.
 */
`timescale 1ns/10ps
`include "cluster_macros.svh"
`default_nettype none

module group_dma_engine #(
  parameter cluster_cfg_pkg::group_id_t GroupId = '0
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  dma_pkg::dma_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output dma_pkg::dma_meta_t meta_o
);

  import dma_pkg::*;
  import cluster_cfg_pkg::*;

  localparam int unsigned BeatShift = $clog2(`BEAT_BYTES);
  localparam int unsigned BeatW     = `LEN_W - BeatShift + 1;
  localparam int unsigned SpanShift = $clog2(`GROUP_SPAN);

  // First address past the whole cluster TCDM
  localparam logic [`ADDR_W-1:0] TcdmEnd = `TCDM_BASE + NumGroups * `GROUP_SPAN;

  logic                busy_q;
  logic [BeatW-1:0]    beat_cnt_q;
  logic [MetaCntW-1:0] done_cnt_q;
  logic [MetaCntW-1:0] err_cnt_q;

  logic                accept;
  logic [`ADDR_W:0]    last_addr;
  logic [`ADDR_W-1:0]  first_off;
  logic [`ADDR_W-1:0]  last_off;
  group_id_t           first_grp;
  group_id_t           last_grp;
  logic                in_slice;
  logic [`LEN_W:0]     len_round;
  logic [BeatW-1:0]    num_beats;

  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & req_ready_o;

  // Last byte touched, one extra bit to catch wrap past the address space
  always_comb begin
    last_addr = {1'b0, req_i.dst_addr} + {{(`ADDR_W + 1 - `LEN_W){1'b0}}, req_i.num_bytes};
    if (req_i.num_bytes != '0) begin
      last_addr = last_addr - 1'b1;
    end
  end

  assign first_off = req_i.dst_addr - `TCDM_BASE;
  assign last_off  = last_addr[`ADDR_W-1:0] - `TCDM_BASE;
  assign first_grp = group_id_t'(first_off >> SpanShift);
  assign last_grp  = group_id_t'(last_off >> SpanShift);

  // Both ends inside TCDM and inside this group's slice
  assign in_slice = (req_i.dst_addr >= `TCDM_BASE) &&
                    (last_addr < {1'b0, TcdmEnd}) &&
                    (first_grp == GroupId) &&
                    (last_grp == GroupId);

  // Zero-length transfers still take one beat
  assign len_round = {1'b0, req_i.num_bytes} + (`LEN_W + 1)'(`BEAT_BYTES - 1);
  assign num_beats = (req_i.num_bytes == '0) ? BeatW'(1) : BeatW'(len_round >> BeatShift);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      done_cnt_q <= '0;
      err_cnt_q  <= '0;
    end else begin
      if (accept) begin
        if (in_slice) begin
          busy_q     <= 1'b1;
          beat_cnt_q <= num_beats;
        end else begin
          err_cnt_q <= err_cnt_q + 1'b1;
        end
      end else if (busy_q) begin
        if (beat_cnt_q == BeatW'(1)) begin
          // Last beat
          busy_q     <= 1'b0;
          done_cnt_q <= done_cnt_q + 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q - 1'b1;
        end
      end
    end
  end

  always_comb begin
    meta_o          = '0;
    meta_o.busy     = busy_q;
    meta_o.num_done = done_cnt_q;
    meta_o.num_err  = err_cnt_q;
  end

endmodule : group_dma_engine

`default_nettype wire

//--- hdl/dma_status_collector.sv
/*
 * Status drain: registers each group's DMA status toward the host and
 * forms the cluster-wide busy flag from the registered copies.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_status_collector (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  dma_pkg::dma_meta_t  [cluster_cfg_pkg::NumGroups-1:0] grp_meta_i,
  output dma_pkg::dma_meta_t  [cluster_cfg_pkg::NumGroups-1:0] dma_meta_o,
  output logic                                                cluster_busy_o
);

  import dma_pkg::*;
  import cluster_cfg_pkg::*;

  dma_meta_t [NumGroups-1:0] meta_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
    end else begin
      meta_q <= grp_meta_i;
    end
  end

  assign dma_meta_o = meta_q;

  // Host polls this until every group has gone idle
  always_comb begin
    cluster_busy_o = 1'b0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      cluster_busy_o = cluster_busy_o | meta_q[g].busy;
    end
  end

endmodule : dma_status_collector

`default_nettype wire

//--- hdl/mempool_cluster.sv
/*
 * DMA cluster top: request front end, 2x2 mesh of group engines and the
 * status collector. Instances and wiring only.
 */
`timescale 1ns/10ps
`include "cluster_macros.svh"
`default_nettype none

module mempool_cluster (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // DMA request
  input  dma_pkg::dma_req_t   [cluster_cfg_pkg::NumGroups-1:0] dma_req_i,
  input  logic                [cluster_cfg_pkg::NumGroups-1:0] dma_req_valid_i,
  output logic                [cluster_cfg_pkg::NumGroups-1:0] dma_req_ready_o,
  // DMA status
  output dma_pkg::dma_meta_t  [cluster_cfg_pkg::NumGroups-1:0] dma_meta_o,
  output logic                                                cluster_busy_o
);

  import dma_pkg::*;
  import cluster_cfg_pkg::*;

  dma_req_t  [NumGroups-1:0] grp_req;
  logic      [NumGroups-1:0] grp_req_valid;
  logic      [NumGroups-1:0] grp_req_ready;
  dma_meta_t [NumGroups-1:0] grp_meta;

  dma_req_frontend i_frontend (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .dma_req_i       (dma_req_i      ),
    .dma_req_valid_i (dma_req_valid_i),
    .dma_req_ready_o (dma_req_ready_o),
    .grp_req_o       (grp_req        ),
    .grp_req_valid_o (grp_req_valid  ),
    .grp_req_ready_i (grp_req_ready  )
  );

  for (genvar x = 0; x < `NUM_X; x++) begin : gen_groups_x
    for (genvar y = 0; y < `NUM_Y; y++) begin : gen_groups_y
      localparam int unsigned Idx = x * `NUM_Y + y;

      group_dma_engine #(
        .GroupId (group_id_t'(Idx))
      ) i_group (
        .clk_i       (clk_i             ),
        .arst_n_i    (arst_n_i          ),
        .req_i       (grp_req[Idx]      ),
        .req_valid_i (grp_req_valid[Idx]),
        .req_ready_o (grp_req_ready[Idx]),
        .meta_o      (grp_meta[Idx]     )
      );
    end : gen_groups_y
  end : gen_groups_x

  dma_status_collector i_collector (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .grp_meta_i     (grp_meta      ),
    .dma_meta_o     (dma_meta_o    ),
    .cluster_busy_o (cluster_busy_o)
  );

endmodule : mempool_cluster

`default_nettype wire

//--- testbench/tb_mempool_cluster.sv
/*
 * Testbench for the DMA cluster. Runs a stimulus table through the request
 * ports and checks status timing, slice rejection, back-pressure and lanes.
 */
`timescale 1ns/10ps
`include "cluster_macros.svh"
`default_nettype none

module tb_mempool_cluster;

  import dma_pkg::*;
  import cluster_cfg_pkg::*;

  localparam int unsigned NumRows   = 8;
  localparam int unsigned WaitLimit = 2000;

  typedef logic [`LEN_W-1:0] len_t;

  typedef struct packed {
    group_id_t   grp;
    dma_req_t    req;
    logic        ok;
    logic [15:0] beats;
  } stim_row_t;

  logic                      clk;
  logic                      arst_n;
  dma_req_t  [NumGroups-1:0] dma_req;
  logic      [NumGroups-1:0] dma_req_valid;
  logic      [NumGroups-1:0] dma_req_ready;
  dma_meta_t [NumGroups-1:0] dma_meta;
  logic                      cluster_busy;

  stim_row_t           stim_table [NumRows];
  logic [MetaCntW-1:0] exp_done   [NumGroups];
  logic [MetaCntW-1:0] exp_err    [NumGroups];
  int unsigned         errors;
  int unsigned         timeouts;
  int unsigned         lanes_left;

  mempool_cluster uut (
    .clk_i           (clk          ),
    .arst_n_i        (arst_n       ),
    .dma_req_i       (dma_req      ),
    .dma_req_valid_i (dma_req_valid),
    .dma_req_ready_o (dma_req_ready),
    .dma_meta_o      (dma_meta     ),
    .cluster_busy_o  (cluster_busy )
  );

  always #20 clk = ~clk;

  function automatic stim_row_t make_row(input group_id_t grp, input logic [`ADDR_W-1:0] dst,
                                         input len_t len, input logic ok,
                                         input logic [15:0] beats);
    stim_row_t row;
    row.grp           = grp;
    row.req.src_addr  = {16'h8000, dst[15:0]};
    row.req.dst_addr  = dst;
    row.req.num_bytes = len;
    row.ok            = ok;
    row.beats         = beats;
    return row;
  endfunction

  // Expected idle status of a group from the reference counts
  function automatic dma_meta_t model_meta(input int unsigned g);
    dma_meta_t m;
    m.busy     = 1'b0;
    m.num_done = exp_done[g];
    m.num_err  = exp_err[g];
    return m;
  endfunction

  function automatic logic [15:0] beats_for(input len_t len);
    if (len == '0) begin
      return 16'd1;
    end
    return 16'((int'(len) + `BEAT_BYTES - 1) / `BEAT_BYTES);
  endfunction

  task automatic check_meta(input string name, input dma_meta_t exp, input dma_meta_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected busy=%0b done=%0d err=%0d, %s",
               $time, name, exp.busy, exp.num_done, exp.num_err,
               $sformatf("got busy=%0b done=%0d err=%0d",
                         act.busy, act.num_done, act.num_err));
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      errors++;
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input int unsigned g, input dma_req_t req);
    int unsigned cnt;
    cnt              = 0;
    dma_req[g]       = req;
    dma_req_valid[g] = 1'b1;
    while (!dma_req_ready[g] && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!dma_req_ready[g]) begin
      $display("Timeout at %0t: lane %0d never accepted its request", $time, g);
      timeouts++;
    end
    @(negedge clk);
    dma_req_valid[g] = 1'b0;
  endtask

  // Only one group is active here, so the cluster flag follows its busy bit
  task automatic busy_run(input int unsigned g, input logic [15:0] beats);
    int unsigned cnt;
    cnt = 0;
    while (!dma_meta[g].busy && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!dma_meta[g].busy) begin
      $display("Timeout at %0t: group %0d never reported busy", $time, g);
      timeouts++;
    end else begin
      check_bit("cluster_busy_o", 1'b1, cluster_busy);
      for (int unsigned i = 1; i < beats; i++) begin
        @(negedge clk);
        check_bit($sformatf("dma_meta_o[%0d].busy", g), 1'b1, dma_meta[g].busy);
        check_bit("cluster_busy_o", 1'b1, cluster_busy);
      end
      @(negedge clk);
      check_bit($sformatf("dma_meta_o[%0d].busy", g), 1'b0, dma_meta[g].busy);
      check_bit("cluster_busy_o", 1'b0, cluster_busy);
    end
  endtask

  // Rejected requests must never show busy
  task automatic wait_err(input int unsigned g);
    int unsigned cnt;
    cnt = 0;
    while (dma_meta[g].num_err != exp_err[g] && cnt < WaitLimit) begin
      @(negedge clk);
      check_bit($sformatf("dma_meta_o[%0d].busy", g), 1'b0, dma_meta[g].busy);
      cnt++;
    end
    if (dma_meta[g].num_err != exp_err[g]) begin
      $display("Timeout at %0t: group %0d error count never advanced", $time, g);
      timeouts++;
    end
  endtask

  task automatic lane_sender(input int unsigned g);
    stim_row_t   row;
    int unsigned gap;
    for (int i = 0; i < NumRows; i++) begin
      row = stim_table[i];
      if (row.grp == g) begin
        gap = $urandom % 8;
        repeat (gap) @(negedge clk);
        send_req(g, row.req);
        if (row.ok) begin
          exp_done[g] = exp_done[g] + 1'b1;
        end else begin
          exp_err[g] = exp_err[g] + 1'b1;
        end
      end
    end
    lanes_left--;
  endtask

  initial begin
    stim_row_t   row;
    dma_req_t    bp_req [4];
    dma_meta_t   m;
    int unsigned cnt;
    int unsigned busy_cnt;
    int unsigned max_busy;
    logic        all_match;
    void'($urandom(32'h8180_6d74));
    clk           = 1'b0;
    arst_n        = 1'b0;
    dma_req       = '0;
    dma_req_valid = '0;
    errors        = 0;
    timeouts      = 0;
    lanes_left    = 0;
    for (int g = 0; g < NumGroups; g++) begin
      exp_done[g] = '0;
      exp_err[g]  = '0;
    end
    stim_table[0] = make_row(0, `TCDM_BASE + 32'h100, 64, 1'b1, 16);
    stim_table[1] = make_row(1, `TCDM_BASE + `GROUP_SPAN, 0, 1'b1, 1);
    stim_table[2] = make_row(2, `TCDM_BASE + 2 * `GROUP_SPAN + 32'h10, 5, 1'b1, 2);
    stim_table[3] = make_row(3, `TCDM_BASE + 4 * `GROUP_SPAN - 32'd64, 64, 1'b1, 16);
    // Crosses the top of the TCDM by one byte
    stim_table[4] = make_row(3, `TCDM_BASE + 4 * `GROUP_SPAN - 32'd64, 65, 1'b0, 0);
    stim_table[5] = make_row(0, `TCDM_BASE + `GROUP_SPAN + 32'h40, 8, 1'b0, 0);
    stim_table[6] = make_row(2, 32'h0000_1000, 4, 1'b0, 0);
    stim_table[7] = make_row(1, `TCDM_BASE + `GROUP_SPAN + 32'h200, 1000, 1'b1, 250);
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    for (int g = 0; g < NumGroups; g++) begin
      check_meta($sformatf("dma_meta_o[%0d]", g), '0, dma_meta[g]);
      check_bit($sformatf("dma_req_ready_o[%0d]", g), 1'b1, dma_req_ready[g]);
    end
    check_bit("cluster_busy_o", 1'b0, cluster_busy);

    // One request at a time to an idle group
    for (int i = 0; i < NumRows; i++) begin
      row = stim_table[i];
      send_req(row.grp, row.req);
      if (row.ok) begin
        exp_done[row.grp] = exp_done[row.grp] + 1'b1;
        busy_run(row.grp, row.beats);
      end else begin
        exp_err[row.grp] = exp_err[row.grp] + 1'b1;
        wait_err(row.grp);
      end
      check_meta($sformatf("dma_meta_o[%0d]", row.grp), model_meta(row.grp),
                 dma_meta[row.grp]);
    end

    // Four long transfers on group 2 so the fourth meets a full spill register
    for (int k = 0; k < 4; k++) begin
      bp_req[k].src_addr  = 32'h8000_4000 + 32'(k);
      bp_req[k].dst_addr  = `TCDM_BASE + 2 * `GROUP_SPAN + 32'h400 * 32'(k);
      bp_req[k].num_bytes = len_t'(64 + ($urandom % 192));
    end
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          send_req(2, bp_req[k]);
        end
        dma_req[2]       = bp_req[3];
        dma_req_valid[2] = 1'b1;
        check_bit("dma_req_ready_o[2]", 1'b0, dma_req_ready[2]);
        cnt = 0;
        while (!dma_req_ready[2] && cnt < WaitLimit) begin
          @(negedge clk);
          cnt++;
        end
        if (!dma_req_ready[2]) begin
          $display("Timeout at %0t: lane 2 stayed stalled", $time);
          timeouts++;
        end else begin
          // First transfer done and the engine just took the second
          m          = model_meta(2);
          m.num_done = m.num_done + 1'b1;
          check_meta("dma_meta_o[2]", m, dma_meta[2]);
        end
        @(negedge clk);
        dma_req_valid[2] = 1'b0;
      end
      begin
        for (int k = 0; k < 4; k++) begin
          busy_run(2, beats_for(bp_req[k].num_bytes));
        end
      end
    join
    exp_done[2] = exp_done[2] + 8'd4;
    check_meta("dma_meta_o[2]", model_meta(2), dma_meta[2]);

    // All lanes at once
    lanes_left = NumGroups;
    fork
      lane_sender(0);
      lane_sender(1);
      lane_sender(2);
      lane_sender(3);
    join_none
    cnt       = 0;
    max_busy  = 0;
    all_match = 1'b0;
    while (!all_match && cnt < WaitLimit) begin
      @(negedge clk);
      busy_cnt  = 0;
      all_match = (lanes_left == 0);
      for (int g = 0; g < NumGroups; g++) begin
        if (dma_meta[g].busy) begin
          busy_cnt++;
        end
        if (dma_meta[g] !== model_meta(g)) begin
          all_match = 1'b0;
        end
      end
      check_bit("cluster_busy_o", busy_cnt != 0, cluster_busy);
      if (busy_cnt > max_busy) begin
        max_busy = busy_cnt;
      end
      cnt++;
    end
    if (!all_match) begin
      $display("Timeout at %0t: cluster never drained to the expected counts", $time);
      timeouts++;
    end
    if (max_busy < 2) begin
      $display("No two groups were ever busy together, lanes did not overlap");
      errors++;
    end
    check_bit("cluster_busy_o", 1'b0, cluster_busy);
    for (int g = 0; g < NumGroups; g++) begin
      check_meta($sformatf("dma_meta_o[%0d]", g), model_meta(g), dma_meta[g]);
    end

    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_mempool_cluster

`default_nettype wire

//--- mempool_cluster.f
+incdir+hdl
hdl/cluster_cfg_pkg.sv
hdl/dma_pkg.sv
hdl/spill_register.sv
hdl/dma_req_frontend.sv
hdl/group_dma_engine.sv
hdl/dma_status_collector.sv
hdl/mempool_cluster.sv
testbench/tb_mempool_cluster.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA cluster testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -Wno-fatal \
  --top-module tb_mempool_cluster \
  -Mdir "$BUILD_DIR" \
  -f mempool_cluster.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_mempool_cluster" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
